//--- project.f
+incdir+.
riscv_alu_pkg.sv
alu_adder.sv
alu_shifter.sv
alu_logic.sv
alu.sv
exec_ctrl.sv
exec_unit.sv
exec_unit_asserts.sv
tb_exec_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_exec_unit
FILELIST  := project.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test: passed"; \
	else \
		echo "test: failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_exec_unit.sv
// testbench that checks directed and random OP/OP-IMM requests to the execute stage against a model.
`timescale 1ns/1ps
`default_nettype none

`include "riscv_alu_defs.svh"

module tb_exec_unit
    import riscv_alu_pkg::*;
();

    localparam int RESET_CYCLES = 4;
    localparam int MAX_CYCLES   = 2000;  // reset, ~70 directed, ~1300 random cycles, margin.
    localparam int RANDOM_CNT   = 1000;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    logic      clk_i = 1'b0;
    logic      rst_i;
    logic      valid_i;
    exec_req_t req_i;
    logic      valid_o;
    exec_rsp_t rsp_o;

    logic        [31:0] lcg_state = 32'hdefbefb8;
    logic               exp_known = 1'b0;
    logic               exp_valid;
    exec_rsp_t          exp_rsp;
    int                 cycle_cnt = 0;
    int                 n_sent    = 0;
    int                 n_resp    = 0;

    always #5 clk_i = ~clk_i;

    exec_unit u_exec_unit (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (valid_i),
        .req_i   (req_i),
        .valid_o (valid_o),
        .rsp_o   (rsp_o)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};  // weak low bits moved up.
    endfunction

    function automatic exec_req_t make_req(input logic [2:0] f3, input logic alt,
                                           input logic imm, input logic [31:0] a,
                                           input logic [31:0] b);
        exec_req_t r;
        r.funct3     = f3;
        r.funct7_alt = alt;
        r.is_imm     = imm;
        r.opr_a      = a;
        r.opr_b      = b;
        return r;
    endfunction

    function automatic exec_req_t rand_req();
        logic [31:0] ctl;
        logic [31:0] a;
        logic [31:0] b;
        ctl = next_rand();
        a   = next_rand();
        b   = next_rand();
        if (ctl[7:5] == 3'b000) begin
            b = a;  // equal operands for the zero flag.
        end
        if (ctl[10:8] == 3'b000) begin
            a = {ctl[11], {31{~ctl[11]}}};  // signed min or max.
        end
        return make_req(ctl[2:0], ctl[4:3] == 2'b00, ctl[12], a, b);
    endfunction

    // expected response from the decode, illegal and flag rules.
    function automatic exec_rsp_t expect_rsp(input exec_req_t r);
        exec_rsp_t   e;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        lt_s;
        logic        lt_u;
        logic        bad;
        a    = r.opr_a;
        b    = r.opr_b;
        sh   = r.opr_b[4:0];
        lt_s = $signed(a) < $signed(b);
        lt_u = a < b;
        bad  = r.funct7_alt && !r.is_imm && (r.funct3 != F3_ADD) && (r.funct3 != F3_SR);
        e    = '0;
        case (r.funct3)
            F3_ADD: begin
                if (r.funct7_alt && !r.is_imm) begin
                    e.result = a - b;
                    e.zero   = (a == b);
                    e.less   = lt_s;
                end else begin
                    e.result = a + b;
                end
            end
            F3_SLL: begin
                bad      = r.funct7_alt;  // SLLI with bit 30 too.
                e.result = a << sh;
            end
            F3_SLT: begin
                e.result = {{(`ALU_XLEN-1){1'b0}}, lt_s};
                e.zero   = (a == b);
                e.less   = lt_s;
            end
            F3_SLTU: begin
                e.result = {{(`ALU_XLEN-1){1'b0}}, lt_u};
                e.zero   = (a == b);
                e.less   = lt_u;
            end
            F3_XOR: e.result = a ^ b;
            F3_SR: begin
                if (r.funct7_alt) begin
                    e.result = $signed(a) >>> sh;
                end else begin
                    e.result = a >> sh;
                end
            end
            F3_OR:   e.result = a | b;
            default: e.result = a & b;
        endcase
        if (bad) begin
            e         = '0;
            e.illegal = 1'b1;
        end
        return e;
    endfunction

    task automatic send(input exec_req_t r);
        @(negedge clk_i);
        valid_i = 1'b1;
        req_i   = r;
        n_sent  = n_sent + 1;
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            valid_i = 1'b0;
            req_i   = rand_req();  // must not reach rsp_o.
        end
    endtask

    task automatic cmp_pair(input logic [31:0] a, input logic [31:0] b);
        for (int imm = 0; imm < 2; imm++) begin
            send(make_req(F3_SLT, 1'b0, imm[0], a, b));
            send(make_req(F3_SLTU, 1'b0, imm[0], a, b));
        end
    endtask

    task automatic shift_case(input logic [31:0] a, input logic [31:0] b);
        for (int imm = 0; imm < 2; imm++) begin
            send(make_req(F3_SLL, 1'b0, imm[0], a, b));
            send(make_req(F3_SR, 1'b0, imm[0], a, b));
            send(make_req(F3_SR, 1'b1, imm[0], a, b));
        end
    endtask

    task automatic run_directed();
        idle_cycles(3);  // reset values held.
        send(make_req(F3_ADD, 1'b0, 1'b0, 32'h0000_0005, 32'h0000_0007));
        send(make_req(F3_ADD, 1'b0, 1'b0, 32'h7fff_ffff, 32'h0000_0001));
        send(make_req(F3_ADD, 1'b0, 1'b0, 32'hffff_ffff, 32'h0000_0001));
        send(make_req(F3_ADD, 1'b1, 1'b0, 32'h8000_0000, 32'h0000_0001));
        send(make_req(F3_ADD, 1'b1, 1'b0, 32'h0000_0005, 32'h0000_0005));
        send(make_req(F3_ADD, 1'b1, 1'b0, 32'h0000_0000, 32'h0000_0001));
        send(make_req(F3_ADD, 1'b1, 1'b0, 32'h7fff_ffff, 32'h8000_0000));
        send(make_req(F3_ADD, 1'b0, 1'b1, 32'h0000_000a, 32'hffff_fff6));
        send(make_req(F3_ADD, 1'b1, 1'b1, 32'h0000_1234, 32'hffff_fc00));  // legal ADDI.
        idle_cycles(2);
        for (int imm = 0; imm < 2; imm++) begin
            send(make_req(F3_XOR, 1'b0, imm[0], 32'hf0f0_f0f0, 32'hff00_ff00));
            send(make_req(F3_OR, 1'b0, imm[0], 32'hf0f0_f0f0, 32'hff00_ff00));
            send(make_req(F3_AND, 1'b0, imm[0], 32'hf0f0_f0f0, 32'hff00_ff00));
        end
        cmp_pair(32'hffff_ffff, 32'h0000_0001);
        cmp_pair(32'h0000_0001, 32'hffff_ffff);
        cmp_pair(32'h8000_0000, 32'h7fff_ffff);
        cmp_pair(32'h7fff_ffff, 32'h8000_0000);
        cmp_pair(32'h0000_0003, 32'h0000_0003);
        shift_case(32'h8000_0f01, 32'h0000_0000);
        shift_case(32'h8000_0f01, 32'h0000_0001);
        shift_case(32'h8000_0f01, 32'h0000_001f);
        shift_case(32'h8000_0f01, 32'hffff_ffe1);  // only low 5 bits count.
        // bit 30 on register forms other than SUB and SRA.
        for (int f = 1; f < 8; f++) begin
            if (f != 5) begin
                send(make_req(f[2:0], 1'b1, 1'b0, 32'h1234_5678, 32'h1234_5678));
            end
        end
        send(make_req(F3_SLL, 1'b1, 1'b1, 32'h0000_00ff, 32'h0000_0404));
    endtask

    task automatic run_random();
        logic [31:0] gap;
        for (int i = 0; i < RANDOM_CNT; i++) begin
            gap = next_rand();
            if (gap[2:0] == 3'b000) begin
                idle_cycles(int'(gap[4:3]) + 1);
            end
            send(rand_req());
        end
    endtask

    // one-entry expectation pipeline, mirrors the output register.
    always @(posedge clk_i) begin
        if (rst_i) begin
            exp_valid <= 1'b0;
            exp_rsp   <= '0;
        end else begin
            exp_valid <= valid_i;
            if (valid_i) begin
                exp_rsp <= expect_rsp(req_i);
            end
        end
        exp_known <= 1'b1;
    end

    // outputs compared mid-cycle.
    always @(negedge clk_i) begin
        if (exp_known) begin
            if (valid_o === 1'b1) begin
                n_resp = n_resp + 1;
            end
            assert (valid_o === exp_valid && rsp_o === exp_rsp)
            else begin
                $display("ERR %0t: got valid %b result %h zero %b less %b illegal %b", $time,
                         valid_o, rsp_o.result, rsp_o.zero, rsp_o.less, rsp_o.illegal);
                $display("ERR %0t: exp valid %b result %h zero %b less %b illegal %b", $time,
                         exp_valid, exp_rsp.result, exp_rsp.zero, exp_rsp.less, exp_rsp.illegal);
                $display("CHECKS FAILED");
                $fatal(1, "response mismatch");
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst_i   = 1'b1;
        valid_i = 1'b0;
        req_i   = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;
        run_directed();
        run_random();
        idle_cycles(3);  // drain the output register.
        @(posedge clk_i);
        if (n_resp == n_sent) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("checked %0d responses for %0d requests", n_resp, n_sent);
            $display("CHECKS FAILED");
            $fatal(1, "response count mismatch");
        end
    end

endmodule

`default_nettype wire

//--- exec_unit_asserts.sv
// concurrent checks on the execute stage outputs, attached to exec_unit by bind.
`timescale 1ns/1ps
`default_nettype none

module exec_unit_asserts
    import riscv_alu_pkg::*;
(
    input wire logic      clk_i,
    input wire logic      rst_i,
    input wire logic      valid_i,
    input wire logic      valid_o,
    input wire exec_rsp_t rsp_o
);

    reset_clears_valid: assert property (@(posedge clk_i) rst_i |=> !valid_o)
        else $error("valid_o high in the cycle after reset");

    // fixed latency of one cycle.
    valid_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        !$past(rst_i) |-> (valid_o == $past(valid_i)))
        else $error("valid_o is not valid_i delayed by one cycle");

    illegal_clears_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_o.illegal |-> (rsp_o.result == '0 && !rsp_o.zero && !rsp_o.less))
        else $error("illegal response carries a result or flags");

endmodule

bind exec_unit exec_unit_asserts u_exec_unit_asserts (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .valid_o (valid_o),
    .rsp_o   (rsp_o)
);

`default_nettype wire

//--- exec_unit.sv
// top of the integer execute stage, one request in and one response out a cycle later.
`timescale 1ns/1ps
`default_nettype none

`include "riscv_alu_defs.svh"

module exec_unit
    import riscv_alu_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_i,
    input  wire logic      valid_i,
    input  wire exec_req_t req_i,
    output logic           valid_o,
    output exec_rsp_t      rsp_o
);

    alu_op_e              alu_op;
    logic [`ALU_XLEN-1:0] opr_a;
    logic [`ALU_XLEN-1:0] opr_b;
    logic [`ALU_XLEN-1:0] alu_res;
    logic                 alu_zero;
    logic                 alu_less;

    exec_ctrl u_exec_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (valid_i),
        .req_i      (req_i),
        .alu_op_o   (alu_op),
        .opr_a_o    (opr_a),
        .opr_b_o    (opr_b),
        .alu_res_i  (alu_res),
        .alu_zero_i (alu_zero),
        .alu_less_i (alu_less),
        .valid_o    (valid_o),
        .rsp_o      (rsp_o)
    );

    alu u_alu (
        .opr_a_i (opr_a),
        .opr_b_i (opr_b),
        .op_i    (alu_op),
        .res_o   (alu_res),
        .zero_o  (alu_zero),
        .less_o  (alu_less)
    );

endmodule

`default_nettype wire

//--- exec_ctrl.sv
// execute stage control, decodes OP/OP-IMM requests for the ALU and registers the response.
`timescale 1ns/1ps
`default_nettype none

`include "riscv_alu_defs.svh"

module exec_ctrl
    import riscv_alu_pkg::*;
(
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    input  wire logic                 valid_i,
    input  wire exec_req_t            req_i,
    output alu_op_e                   alu_op_o,
    output logic      [`ALU_XLEN-1:0] opr_a_o,
    output logic      [`ALU_XLEN-1:0] opr_b_o,
    input  wire logic [`ALU_XLEN-1:0] alu_res_i,
    input  wire logic                 alu_zero_i,
    input  wire logic                 alu_less_i,
    output logic                      valid_o,
    output exec_rsp_t                 rsp_o
);

    alu_op_e   alu_op;
    logic      illegal;
    logic      alt_reg;
    logic      valid_q;
    exec_rsp_t rsp_q;

    assign alt_reg = req_i.funct7_alt & ~req_i.is_imm;

    // bit 30 only legal on SUB, SRA/SRAI; ADDI treats it as immediate.
    assign illegal = (alt_reg && (req_i.funct3 != 3'b000) && (req_i.funct3 != 3'b101)) ||
                     (req_i.funct7_alt && (req_i.funct3 == 3'b001));

    always_comb begin
        case (req_i.funct3)
            3'b000:  alu_op = alt_reg ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = req_i.funct7_alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    assign alu_op_o = alu_op;
    assign opr_a_o  = req_i.opr_a;
    assign opr_b_o  = req_i.opr_b;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            rsp_q   <= '0;
        end else begin
            valid_q <= valid_i;
            if (valid_i) begin  // hold last response on gaps.
                if (illegal) begin
                    rsp_q.result  <= '0;
                    rsp_q.zero    <= 1'b0;
                    rsp_q.less    <= 1'b0;
                    rsp_q.illegal <= 1'b1;
                end else begin
                    rsp_q.result  <= alu_res_i;
                    rsp_q.zero    <= alu_zero_i;
                    rsp_q.less    <= alu_less_i;
                    rsp_q.illegal <= 1'b0;
                end
            end
        end
    end

    assign valid_o = valid_q;
    assign rsp_o   = rsp_q;

endmodule

`default_nettype wire

//--- alu.sv
// combinational ALU wrapper, drives the adder, shifter and logic units and selects the result.
`timescale 1ns/1ps
`default_nettype none

`include "riscv_alu_defs.svh"

module alu
    import riscv_alu_pkg::*;
(
    input  wire logic    [`ALU_XLEN-1:0] opr_a_i,
    input  wire logic    [`ALU_XLEN-1:0] opr_b_i,
    input  wire alu_op_e                 op_i,
    output logic         [`ALU_XLEN-1:0] res_o,
    output logic                         zero_o,
    output logic                         less_o
);

    logic                 sub_en;
    logic [`ALU_XLEN-1:0] opr_b_neg;
    logic [`ALU_XLEN-1:0] adder_out;
    logic                 adder_carry;
    logic                 adder_v;
    logic [`ALU_XLEN-1:0] shifter_out;
    logic [`ALU_XLEN-1:0] logic_out;
    logic                 less_s;
    logic                 less_u;

    assign sub_en    = op_i[0];  // invert bit of the opcode.
    assign opr_b_neg = sub_en ? ~opr_b_i : opr_b_i;

    // sign of a - b, corrected on overflow.
    assign less_s = adder_out[`ALU_XLEN-1] ^ adder_v;
    assign less_u = ~adder_carry;  // borrow out.

    assign zero_o = sub_en & ~|adder_out;
    assign less_o = ((op_i == ALU_SLT) || (op_i == ALU_SUB)) ? less_s :
                    (op_i == ALU_SLTU)                       ? less_u :
                                                               1'b0;

    always_comb begin
        case (op_i)
            ALU_ADD, ALU_SUB:          res_o = adder_out;
            ALU_SLL, ALU_SRL, ALU_SRA: res_o = shifter_out;
            ALU_AND, ALU_OR, ALU_XOR:  res_o = logic_out;
            ALU_SLT:                   res_o = {{(`ALU_XLEN-1){1'b0}}, less_s};
            ALU_SLTU:                  res_o = {{(`ALU_XLEN-1){1'b0}}, less_u};
            default:                   res_o = '0;
        endcase
    end

    alu_adder u_adder (
        .op1_i   (opr_a_i),
        .op2_i   (opr_b_neg),
        .cin_i   (sub_en),
        .sum_o   (adder_out),
        .carry_o (adder_carry),
        .v_o     (adder_v)
    );

    alu_shifter u_shifter (
        .op1_i   (opr_a_i),
        .shamt_i (opr_b_i[`ALU_SHAMT_W-1:0]),
        .op_i    (op_i),
        .res_o   (shifter_out)
    );

    alu_logic u_logic (
        .op1_i (opr_a_i),
        .op2_i (opr_b_i),
        .op_i  (op_i),
        .res_o (logic_out)
    );

endmodule

`default_nettype wire

//--- alu_logic.sv
// bitwise unit of the ALU, giving AND, OR or XOR of the two operands.
`timescale 1ns/1ps
`default_nettype none

`include "riscv_alu_defs.svh"

module alu_logic
    import riscv_alu_pkg::*;
(
    input  wire logic    [`ALU_XLEN-1:0] op1_i,
    input  wire logic    [`ALU_XLEN-1:0] op2_i,
    input  wire alu_op_e                 op_i,
    output logic         [`ALU_XLEN-1:0] res_o
);

    always_comb begin
        case (op_i)
            ALU_AND: res_o = op1_i & op2_i;
            ALU_OR:  res_o = op1_i | op2_i;
            ALU_XOR: res_o = op1_i ^ op2_i;
            default: res_o = '0;  // not a logic op.
        endcase
    end

endmodule

`default_nettype wire

//--- alu_shifter.sv
// barrel shifter of the ALU, used for SLL, SRL and SRA in register and immediate form.
`timescale 1ns/1ps
`default_nettype none

`include "riscv_alu_defs.svh"

module alu_shifter
    import riscv_alu_pkg::*;
(
    input  wire logic    [`ALU_XLEN-1:0]    op1_i,
    input  wire logic    [`ALU_SHAMT_W-1:0] shamt_i,
    input  wire alu_op_e                    op_i,
    output logic         [`ALU_XLEN-1:0]    res_o
);

    logic signed [`ALU_XLEN-1:0] op1_s;

    assign op1_s = $signed(op1_i);

    always_comb begin
        case (op_i)
            ALU_SLL: begin
                res_o = op1_i << shamt_i;
            end
            ALU_SRA: begin
                res_o = op1_s >>> shamt_i;  // sign fill.
            end
            default: begin
                res_o = op1_i >> shamt_i;   // zero fill.
            end
        endcase
    end

endmodule

`default_nettype wire

//--- alu_adder.sv
// behavioral adder of the ALU, shared by add, subtract and the set-less-than compares.
`timescale 1ns/1ps
`default_nettype none

`include "riscv_alu_defs.svh"

module alu_adder (
    input  wire logic [`ALU_XLEN-1:0] op1_i,
    input  wire logic [`ALU_XLEN-1:0] op2_i,
    input  wire logic                 cin_i,
    output logic      [`ALU_XLEN-1:0] sum_o,
    output logic                      carry_o,
    output logic                      v_o
);

    logic [`ALU_XLEN:0] sum_ext;

    assign sum_ext = {1'b0, op1_i} + {1'b0, op2_i} + {{`ALU_XLEN{1'b0}}, cin_i};
    assign sum_o   = sum_ext[`ALU_XLEN-1:0];
    assign carry_o = sum_ext[`ALU_XLEN];

    // same input signs, different result sign.
    assign v_o = (op1_i[`ALU_XLEN-1] == op2_i[`ALU_XLEN-1]) &&
                 (sum_o[`ALU_XLEN-1] != op1_i[`ALU_XLEN-1]);

endmodule

`default_nettype wire

//--- riscv_alu_pkg.sv
// shared opcode and request/response types of the execute stage, imported by the RTL modules.
`default_nettype none

`include "riscv_alu_defs.svh"

package riscv_alu_pkg;

    // bit 0 set means operand b inverted and carry-in of one.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,  // subtracting adder.
        ALU_SLL  = 4'h2,
        ALU_SLT  = 4'h3,  // subtracting adder.
        ALU_XOR  = 4'h4,
        ALU_SLTU = 4'h5,  // subtracting adder.
        ALU_SRL  = 4'h6,
        ALU_SRA  = 4'h8,
        ALU_OR   = 4'hA,
        ALU_AND  = 4'hC
    } alu_op_e;

    // one decoded OP or OP-IMM instruction.
    typedef struct packed {
        logic [2:0]           funct3;
        logic                 funct7_alt;  // instruction bit 30.
        logic                 is_imm;
        logic [`ALU_XLEN-1:0] opr_a;
        logic [`ALU_XLEN-1:0] opr_b;       // immediate already sign-extended.
    } exec_req_t;

    // registered stage output.
    typedef struct packed {
        logic [`ALU_XLEN-1:0] result;
        logic                 zero;
        logic                 less;
        logic                 illegal;
    } exec_rsp_t;

endpackage

`default_nettype wire

//--- riscv_alu_defs.svh
// width macros for the execute stage, included by the package and every ALU source file.
`ifndef RISCV_ALU_DEFS_SVH
`define RISCV_ALU_DEFS_SVH

// data path width, one RV32I register.
`define ALU_XLEN 32

// shift amount field, low bits of operand b.
`define ALU_SHAMT_W 5

`endif
